/* source/memTypesPkg.sv */
`default_nettype none

package memTypesPkg;

    localparam int addrBits = 32;
    localparam int wordBits = 32;
    localparam int byteBits = 8;
    localparam int lenBits  = 3;

    typedef logic [addrBits-1:0] addrT;
    typedef logic [byteBits-1:0] byteT;
    typedef logic [wordBits-1:0] wordT;
    // access length in bytes, 1, 2 or 4
    typedef logic [lenBits-1:0]  lenT;

    typedef enum logic [3:0] {
        opLb,
        opLh,
        opLw,
        opLbu,
        opLhu,
        opSb,
        opSh,
        opSw
    } memOpT;

endpackage

`default_nettype wire

/* source/memCtrlPkg.sv */
`default_nettype none

package memCtrlPkg;

    typedef enum logic [1:0] {
        idle,
        readInst,
        readData,
        writeData
    } ctrlStateT;

    // byte counter within one access
    typedef logic [2:0] stageT;

endpackage

`default_nettype wire

/* source/byteRam.sv */
`timescale 1ns/1ps
`default_nettype none

module byteRam import memTypesPkg::*; #(
    parameter int ramAddrBits = 12
) (
    input  wire  clk,
    input  wire  we,
    input  addrT addr,
    input  byteT din,
    output byteT dout
);

    byteT mem [2**ramAddrBits];

    initial begin
        for (int i = 0; i < 2**ramAddrBits; i++) begin
            mem[i] = '0;
        end
    end

    // read byte is registered, so dout lags addr by one cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[ramAddrBits-1:0]] <= din;
        end
        dout <= mem[addr[ramAddrBits-1:0]];
    end

endmodule

`default_nettype wire

/* source/memCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrl import memTypesPkg::*, memCtrlPkg::*; (
    input  wire  clk,
    input  wire  rst,
    input  wire  rdy,
    input  wire  ioBufferFull,

    input  wire  fetchEn,
    input  addrT fetchAddr,
    output logic fetchDone,
    output wordT fetchInst,

    input  wire  dataEn,
    input  wire  dataStore,
    input  lenT  dataLen,
    input  addrT dataAddr,
    input  wordT dataWrite,
    output logic dataDone,
    output wordT dataRead,

    output logic ramWe,
    output addrT ramAddr,
    output byteT ramDin,
    input  byteT ramDout
);

    ctrlStateT   state;
    stageT       stage;
    stageT       idx;
    logic        stall;
    logic        done;
    addrT        base;
    lenT         len;
    wordT        wdata;
    logic [23:0] hold;

    assign stall = !rdy || ioBufferFull;

    // last stage of the active access
    assign done = (state != idle) && (stage == stageT'(len)) && !stall;

    assign fetchDone = done && (state == readInst);
    assign dataDone  = done && (state != readInst);

    // reads run one byte ahead of the stage; a stall re-presents the previous address
    assign idx = (state == writeData || stall) ? stage - stageT'(1) : stage;

    always_comb begin
        if (state == idle) begin
            ramAddr = dataEn ? dataAddr : fetchAddr;
        end else begin
            ramAddr = base + addrT'(idx);
        end
    end

    assign ramWe  = (state == writeData) && !stall;
    assign ramDin = wdata[{idx[1:0], 3'b000} +: 8];

    assign fetchInst = {ramDout, hold};

    // raw bytes, zero above the access length
    always_comb begin
        case (len)
            3'd1:    dataRead = {24'h0, ramDout};
            3'd2:    dataRead = {16'h0, ramDout, hold[7:0]};
            default: dataRead = {ramDout, hold};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            stage <= '0;
        end else if (!stall) begin
            case (state)
                idle: begin
                    if (dataEn) begin
                        state <= dataStore ? writeData : readData;
                        stage <= stageT'(1);
                    end else if (fetchEn) begin
                        state <= readInst;
                        stage <= stageT'(1);
                    end
                end
                default: begin
                    if (stage == stageT'(len)) begin
                        state <= idle;
                    end else begin
                        stage <= stage + stageT'(1);
                    end
                end
            endcase
        end
    end

    // latched request and collected bytes
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == idle) begin
                if (dataEn) begin
                    base  <= dataAddr;
                    len   <= dataLen;
                    wdata <= dataWrite;
                end else if (fetchEn) begin
                    base <= fetchAddr;
                    len  <= lenT'(4);
                end
            end else if (state != writeData && stage != stageT'(len)) begin
                case (stage)
                    3'd1:    hold[7:0]   <= ramDout;
                    3'd2:    hold[15:8]  <= ramDout;
                    3'd3:    hold[23:16] <= ramDout;
                    default: hold        <= hold;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/loadStoreUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit import memTypesPkg::*; (
    input  wire   clk,
    input  wire   rst,

    input  wire   lsuEn,
    input  memOpT lsuOp,
    input  addrT  lsuAddr,
    input  wordT  lsuWrite,
    output logic  lsuDone,
    output wordT  lsuRead,
    output logic  lsuBusy,

    output logic  dataEn,
    output logic  dataStore,
    output lenT   dataLen,
    output addrT  dataAddr,
    output wordT  dataWrite,
    input  wire   dataDone,
    input  wordT  dataRead
);

    memOpT op;
    logic  busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (!busy && lsuEn) begin
            busy <= 1'b1;
        end else if (dataDone) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && lsuEn) begin
            op        <= lsuOp;
            dataAddr  <= lsuAddr;
            dataWrite <= lsuWrite;
        end
    end

    assign lsuBusy = busy;
    assign dataEn  = busy;
    assign lsuDone = dataDone;

    assign dataStore = (op == opSb) || (op == opSh) || (op == opSw);

    always_comb begin
        case (op)
            opLb, opLbu, opSb: dataLen = lenT'(1);
            opLh, opLhu, opSh: dataLen = lenT'(2);
            default:           dataLen = lenT'(4);
        endcase
    end

    // extension of the raw bytes
    always_comb begin
        case (op)
            opLb:    lsuRead = {{24{dataRead[7]}}, dataRead[7:0]};
            opLh:    lsuRead = {{16{dataRead[15]}}, dataRead[15:0]};
            opLw:    lsuRead = dataRead;
            opLbu:   lsuRead = {24'h0, dataRead[7:0]};
            opLhu:   lsuRead = {16'h0, dataRead[15:0]};
            default: lsuRead = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import memTypesPkg::*; #(
    parameter addrT resetPc = '0
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  instTake,
    input  wire  redirect,
    input  addrT redirectPc,
    output logic instValid,
    output wordT inst,
    output addrT instPc,
    output logic fetchEn,
    output addrT fetchAddr,
    input  wire  fetchDone,
    input  wordT fetchInst
);

    addrT pc;
    addrT reqPc;
    logic busy;
    // in-flight result belongs to a stale pc
    logic discard;

    assign fetchEn   = busy;
    assign fetchAddr = reqPc;
    assign instPc    = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= resetPc;
            busy      <= 1'b0;
            discard   <= 1'b0;
            instValid <= 1'b0;
        end else begin
            if (fetchDone) begin
                busy    <= 1'b0;
                discard <= 1'b0;
                if (!discard && !redirect) begin
                    instValid <= 1'b1;
                end
            end else if (!busy && !instValid) begin
                busy <= 1'b1;
            end
            if (redirect) begin
                pc        <= redirectPc;
                instValid <= 1'b0;
                if (busy && !fetchDone) begin
                    discard <= 1'b1;
                end
            end else if (instValid && instTake) begin
                pc        <= pc + addrT'(4);
                instValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            inst <= fetchInst;
        end
        if (!busy && !instValid) begin
            reqPc <= redirect ? redirectPc : pc;
        end
    end

endmodule

`default_nettype wire

/* source/memSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystem import memTypesPkg::*; #(
    parameter int   ramAddrBits = 12,
    parameter addrT resetPc     = '0
) (
    input  wire   clk,
    input  wire   rst,
    input  wire   rdy,
    input  wire   ioBufferFull,

    output logic  instValid,
    output wordT  inst,
    output addrT  instPc,
    input  wire   instTake,
    input  wire   redirect,
    input  addrT  redirectPc,

    input  wire   lsuEn,
    input  memOpT lsuOp,
    input  addrT  lsuAddr,
    input  wordT  lsuWrite,
    output logic  lsuDone,
    output wordT  lsuRead,
    output logic  lsuBusy
);

    logic fetchEn;
    addrT fetchAddr;
    logic fetchDone;
    wordT fetchInst;

    logic dataEn;
    logic dataStore;
    lenT  dataLen;
    addrT dataAddr;
    wordT dataWrite;
    logic dataDone;
    wordT dataRead;

    logic ramWe;
    addrT ramAddr;
    byteT ramDin;
    byteT ramDout;

    fetchUnit #(
        .resetPc(resetPc)
    ) u_fetch (
        .clk(clk), .rst(rst),
        .instTake(instTake), .redirect(redirect), .redirectPc(redirectPc),
        .instValid(instValid), .inst(inst), .instPc(instPc),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr),
        .fetchDone(fetchDone), .fetchInst(fetchInst)
    );

    loadStoreUnit u_lsu (
        .clk(clk), .rst(rst),
        .lsuEn(lsuEn), .lsuOp(lsuOp), .lsuAddr(lsuAddr), .lsuWrite(lsuWrite),
        .lsuDone(lsuDone), .lsuRead(lsuRead), .lsuBusy(lsuBusy),
        .dataEn(dataEn), .dataStore(dataStore), .dataLen(dataLen),
        .dataAddr(dataAddr), .dataWrite(dataWrite),
        .dataDone(dataDone), .dataRead(dataRead)
    );

    memCtrl u_ctrl (
        .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr),
        .fetchDone(fetchDone), .fetchInst(fetchInst),
        .dataEn(dataEn), .dataStore(dataStore), .dataLen(dataLen),
        .dataAddr(dataAddr), .dataWrite(dataWrite),
        .dataDone(dataDone), .dataRead(dataRead),
        .ramWe(ramWe), .ramAddr(ramAddr), .ramDin(ramDin), .ramDout(ramDout)
    );

    byteRam #(
        .ramAddrBits(ramAddrBits)
    ) u_ram (
        .clk(clk),
        .we(ramWe),
        .addr(ramAddr),
        .din(ramDin),
        .dout(ramDout)
    );

endmodule

`default_nettype wire

/* testbench/memSubsystem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystem_checker import memCtrlPkg::*; (
    input wire       clk,
    input wire       rst,
    input wire       rdy,
    input wire       ioBufferFull,
    input wire       fetchDone,
    input wire       dataDone,
    input wire       ramWe,
    input ctrlStateT state
);

    logic stall;

    assign stall = !rdy || ioBufferFull;

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dataDone))
        else $error("fetchDone and dataDone high together");

    // no completion while the controller is frozen
    noDoneInStall: assert property (@(posedge clk) disable iff (rst)
        (fetchDone || dataDone) |-> !stall)
        else $error("done pulse during stall");

    noWriteIdle: assert property (@(posedge clk) disable iff (rst)
        (stall || state == idle) |-> !ramWe)
        else $error("ramWe high in stall or idle");

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone)
        else $error("fetchDone longer than one cycle");

    dataDonePulse: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataDone)
        else $error("dataDone longer than one cycle");

endmodule

bind memCtrl memSubsystem_checker u_checker (
    .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
    .fetchDone(fetchDone), .dataDone(dataDone), .ramWe(ramWe), .state(state)
);

`default_nettype wire

/* testbench/memSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb import memTypesPkg::*; ;

    localparam int numOps     = 300;
    localparam int phase1Ops  = 60;
    // about ten cycles per operation with fetch contention and stalls
    localparam int cycleLimit = numOps * 10;
    localparam int ramBytes   = 4096;
    localparam addrT fetchTop = 32'h700;

    logic clk = 1'b0;
    logic rst, rdy, ioBufferFull;
    logic instValid, instTake, redirect;
    wordT inst;
    addrT instPc, redirectPc;
    logic lsuEn, lsuDone, lsuBusy;
    memOpT lsuOp;
    addrT lsuAddr;
    wordT lsuWrite, lsuRead;

    byteT shadow [ramBytes];
    int seed = 32'h677e;
    int errors, cycles, opCount, issued, instChecks;
    logic pending, checkInst, armInst, switched, started, finished;
    memOpT curOp;
    addrT curAddr, expPc;
    wordT curWrite, curExpect;

    always #50 clk = ~clk;

    memSubsystem #(.ramAddrBits(12), .resetPc('0)) u_dut (
        .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
        .instValid(instValid), .inst(inst), .instPc(instPc),
        .instTake(instTake), .redirect(redirect), .redirectPc(redirectPc),
        .lsuEn(lsuEn), .lsuOp(lsuOp), .lsuAddr(lsuAddr), .lsuWrite(lsuWrite),
        .lsuDone(lsuDone), .lsuRead(lsuRead), .lsuBusy(lsuBusy)
    );

    function automatic bit isStore(memOpT op);
        return op == opSb || op == opSh || op == opSw;
    endfunction

    function automatic wordT shadowWord(addrT a);
        int i;
        i = int'(a[11:0]);
        return {shadow[i+3], shadow[i+2], shadow[i+1], shadow[i]};
    endfunction

    // little-endian bytes, extended as the load kind says
    function automatic wordT expectLoad(memOpT op, addrT a);
        int i;
        i = int'(a[11:0]);
        case (op)
            opLb:    return {{24{shadow[i][7]}}, shadow[i]};
            opLbu:   return {24'h0, shadow[i]};
            opLh:    return {{16{shadow[i+1][7]}}, shadow[i+1], shadow[i]};
            opLhu:   return {16'h0, shadow[i+1], shadow[i]};
            opLw:    return shadowWord(a);
            default: return '0;
        endcase
    endfunction

    task automatic commitStore(memOpT op, addrT a, wordT w);
        int i;
        i = int'(a[11:0]);
        shadow[i] = w[7:0];
        if (op != opSb) begin
            shadow[i+1] = w[15:8];
        end
        if (op == opSw) begin
            shadow[i+2] = w[23:16];
            shadow[i+3] = w[31:24];
        end
    endtask

    function automatic addrT alignFor(memOpT op, addrT a);
        case (op)
            opLb, opLbu, opSb: return a;
            opLh, opLhu, opSh: return a & ~addrT'(1);
            default:           return a & ~addrT'(3);
        endcase
    endfunction

    task automatic reportMismatch(string name, wordT expected, wordT actual);
        $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        errors++;
    endtask

    task automatic issueOp();
        int r;
        int k;
        r = $random(seed);
        k = int'($unsigned(r) % 3);
        if (issued < phase1Ops || r[8]) begin
            curOp = (k == 0) ? opSb : (k == 1) ? opSh : opSw;
        end else begin
            curOp = memOpT'({1'b0, r[2:0]} % 4'd5);
        end
        r = $random(seed);
        curAddr = addrT'(r) & addrT'(32'hFFF);
        // later stores stay above the fetch region
        if (issued >= phase1Ops && isStore(curOp)) begin
            curAddr = curAddr | addrT'(32'h800);
        end
        curAddr = alignFor(curOp, curAddr);
        curWrite = wordT'($random(seed));
        curExpect = expectLoad(curOp, curAddr);
        lsuEn <= 1'b1;
        lsuOp <= curOp;
        lsuAddr <= curAddr;
        lsuWrite <= curWrite;
        issued++;
    endtask

    task automatic stepCycle();
        int r;
        bit drove;
        drove = 0;
        cycles++;
        if (lsuDone && (!rdy || ioBufferFull)) begin
            $display("lsuDone seen while the controller was stalled");
            errors++;
        end
        if (lsuDone) begin
            if (!pending) begin
                $display("lsuDone without an outstanding request");
                errors++;
            end else if (isStore(curOp)) begin
                commitStore(curOp, curAddr, curWrite);
                if (lsuRead != '0) begin
                    reportMismatch("store read", '0, lsuRead);
                end
            end else if (lsuRead != curExpect) begin
                reportMismatch("load", curExpect, lsuRead);
            end
            pending = 0;
            opCount++;
        end
        if (lsuEn) begin
            pending = 1;
            lsuEn <= 1'b0;
        end else if (started && !pending && issued < numOps &&
                     (issued < phase1Ops || switched)) begin
            issueOp();
            drove = 1;
        end

        if (instValid) begin
            if (!started && instPc != '0) begin
                reportMismatch("reset pc", '0, instPc);
            end
            started = 1;
            if (instPc != expPc) begin
                reportMismatch("fetch pc", expPc, instPc);
            end
            if (checkInst) begin
                instChecks++;
                if (inst != shadowWord(instPc)) begin
                    reportMismatch("fetch inst", shadowWord(instPc), inst);
                end
            end
        end
        if (redirect) begin
            expPc = redirectPc;
            if (armInst) begin
                checkInst = 1;
                armInst = 0;
            end
        end else if (instValid && instTake) begin
            expPc = instPc + 4;
        end

        r = $random(seed);
        redirect <= 1'b0;
        if (!switched && issued == phase1Ops && !pending && !drove) begin
            switched = 1;
            armInst = 1;
            redirect <= 1'b1;
            redirectPc <= addrT'($random(seed)) & addrT'(32'h6FC);
        end else if (started && (r[4:0] == 0 || expPc >= fetchTop)) begin
            redirect <= 1'b1;
            redirectPc <= addrT'($random(seed)) & addrT'(32'h6FC);
        end
        instTake <= r[5];
        rdy <= (r[11:8] != 0);
        ioBufferFull <= (r[15:12] == 0);
        finished = (opCount == numOps) && !pending;
    endtask

    initial begin
        for (int i = 0; i < ramBytes; i++) begin
            shadow[i] = '0;
        end
        errors = 0;
        cycles = 0;
        opCount = 0;
        issued = 0;
        instChecks = 0;
        pending = 0;
        checkInst = 1;
        armInst = 0;
        switched = 0;
        started = 0;
        finished = 0;
        expPc = '0;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        instTake = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        lsuEn = 1'b0;
        lsuOp = opLw;
        lsuAddr = '0;
        lsuWrite = '0;
        repeat (4) @(posedge clk);
        if (lsuBusy || lsuDone || instValid) begin
            $display("outputs not idle after reset");
            errors++;
        end
        rst <= 1'b0;
        // first fetch is checked against zeroed memory, then stores begin
        while (!finished && cycles < cycleLimit) begin
            @(posedge clk);
            if (started) begin
                checkInst = checkInst && switched;
            end
            stepCycle();
        end
        if (!finished) begin
            $display("timeout after %0d cycles with %0d operations done", cycles, opCount);
            errors++;
        end
        if (instChecks == 0) begin
            $display("no instruction was checked");
            errors++;
        end
        $display("%0d operations, %0d fetch checks, %0d errors", opCount, instChecks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* memsys.f */
source/memTypesPkg.sv
source/memCtrlPkg.sv
source/byteRam.sv
source/memCtrl.sv
source/loadStoreUnit.sv
source/fetchUnit.sv
source/memSubsystem.sv
testbench/memSubsystem_checker.sv
testbench/memSubsystemTb.sv

/* build.sh */
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module memSubsystemTb -f memsys.f -o simMemSubsystem
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simMemSubsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0
